//--- build.f
rtl/cpu_cfg_pkg.sv
rtl/mem_op_pkg.sv
rtl/llbit_ctrl.sv
rtl/mem_req_gen.sv
rtl/load_align.sv
rtl/mem_stage.sv
tests/tb_clk_gen.sv
tests/tb_mem_stage.sv

//--- rtl/cpu_cfg_pkg.sv
// word, register-index and byte-lane types shared by every module of the memory-access stage
`default_nettype none

package cpu_cfg_pkg;

  // data and address width
  localparam int WORD_W = 32;

  // register-file destination index width
  localparam int REG_ADDR_W = 5;

  // byte lanes in one word
  localparam int BYTE_SEL_W = WORD_W / 8;

  // one data or address word
  typedef logic [WORD_W-1:0] word_t;

  // write-back destination register
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // one bit per byte lane, bit 0 is the lowest byte
  typedef logic [BYTE_SEL_W-1:0] byte_sel_t;

  localparam word_t ZERO_WORD = '0;

endpackage

`default_nettype wire

//--- rtl/llbit_ctrl.sv
// link-bit register for LL/SC, set by a completed LL and cleared by a passing SC
`default_nettype none
`timescale 1ns/1ps

module llbit_ctrl (
  input  wire                      clk,
  input  wire                      arst_n_i,
  input  wire mem_op_pkg::aluop_t  aluop_i,
  input  wire                      stall_i,
  output logic                     sc_pass_o
);
  import mem_op_pkg::*;

  logic llbit;
  logic is_ll;
  logic is_sc;

  assign is_ll = (aluop_i == OP_LL);
  assign is_sc = (aluop_i == OP_SC);

  // the only place the store-conditional condition is evaluated
  assign sc_pass_o = is_sc & llbit;

  // update only on the edge where the access completes
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      llbit <= 1'b0;
    end
    else if (!stall_i)
    begin
      if (is_ll)
      begin
        llbit <= 1'b1;
      end
      else if (sc_pass_o)
      begin
        // a successful SC consumes the reservation
        llbit <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/load_align.sv
// write-back result former, aligns and extends load data and merges the unaligned word loads
`default_nettype none
`timescale 1ns/1ps

module load_align (
  input  wire                        arst_n_i,
  input  wire mem_op_pkg::aluop_t    aluop_i,
  input  wire cpu_cfg_pkg::word_t    mem_addr_i,
  input  wire cpu_cfg_pkg::word_t    reg2_i,
  input  wire cpu_cfg_pkg::word_t    mem_data_i,
  input  wire                        sc_pass_i,
  input  wire cpu_cfg_pkg::reg_addr_t wd_i,
  input  wire                        wreg_i,
  input  wire cpu_cfg_pkg::word_t    wdata_i,
  output cpu_cfg_pkg::reg_addr_t     wd_o,
  output logic                       wreg_o,
  output cpu_cfg_pkg::word_t         wdata_o
);
  import cpu_cfg_pkg::*;
  import mem_op_pkg::*;

  logic [1:0]  offset;
  logic [1:0]  inv_offset;
  logic [4:0]  shamt_l;
  logic [4:0]  shamt_r;
  logic        half_ok;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;
  word_t       lwl_data;
  word_t       lwr_data;

  assign offset     = mem_addr_i[1:0];
  assign inv_offset = 2'd3 - offset;
  assign shamt_l    = {offset, 3'b000};
  assign shamt_r    = {inv_offset, 3'b000};
  assign half_ok    = ~offset[0];

  // addressed byte and halfword of the returned word
  assign rd_byte = mem_data_i[shamt_l +: 8];
  assign rd_half = mem_data_i[{offset[1], 4'b0000} +: 16];

  // LWL keeps the low 8k bits of reg2, memory fills the rest from below
  assign lwl_data = (mem_data_i << shamt_l) |
                    (reg2_i & ~({WORD_W{1'b1}} << shamt_l));

  // LWR keeps the top 8(3-k) bits of reg2, memory fills the rest from above
  assign lwr_data = (mem_data_i >> shamt_r) |
                    (reg2_i & ~({WORD_W{1'b1}} >> shamt_r));

  always_comb
  begin
    case (aluop_i)
      OP_LB:
      begin
        wdata_o = {{(WORD_W-8){rd_byte[7]}}, rd_byte};
      end
      OP_LBU:
      begin
        wdata_o = {{(WORD_W-8){1'b0}}, rd_byte};
      end
      OP_LH:
      begin
        wdata_o = half_ok ? {{(WORD_W-16){rd_half[15]}}, rd_half} : ZERO_WORD;
      end
      OP_LHU:
      begin
        wdata_o = half_ok ? {{(WORD_W-16){1'b0}}, rd_half} : ZERO_WORD;
      end
      OP_LW, OP_LL:
      begin
        wdata_o = mem_data_i;
      end
      OP_LWL:
      begin
        wdata_o = lwl_data;
      end
      OP_LWR:
      begin
        wdata_o = lwr_data;
      end
      OP_SC:
      begin
        // success flag written back to rt
        wdata_o = {{(WORD_W-1){1'b0}}, sc_pass_i};
      end
      default:
      begin
        wdata_o = wdata_i;
      end
    endcase
  end

  assign wd_o   = wd_i;
  assign wreg_o = arst_n_i & wreg_i;

endmodule

`default_nettype wire

//--- rtl/mem_op_pkg.sv
// operation type from execute and the load/store codes decoded by the memory-access stage
`default_nettype none

package mem_op_pkg;

  // operation code as delivered by execute
  typedef logic [7:0] aluop_t;

  // loads, byte and halfword
  localparam aluop_t OP_LB  = 8'b1110_0000;
  localparam aluop_t OP_LBU = 8'b1110_0100;
  localparam aluop_t OP_LH  = 8'b1110_0001;
  localparam aluop_t OP_LHU = 8'b1110_0101;

  // loads, full and unaligned word
  localparam aluop_t OP_LW  = 8'b1110_0011;
  localparam aluop_t OP_LWL = 8'b1110_0010;
  localparam aluop_t OP_LWR = 8'b1110_0110;

  // stores, byte, halfword and word
  localparam aluop_t OP_SB  = 8'b1110_1000;
  localparam aluop_t OP_SH  = 8'b1110_1001;
  localparam aluop_t OP_SW  = 8'b1110_1011;

  // stores, unaligned word
  localparam aluop_t OP_SWL = 8'b1110_1010;
  localparam aluop_t OP_SWR = 8'b1110_1110;

  // atomic pair, load-linked and store-conditional
  localparam aluop_t OP_LL  = 8'b1111_0000;
  localparam aluop_t OP_SC  = 8'b1111_1000;

endpackage

`default_nettype wire

//--- rtl/mem_req_gen.sv
// data-memory request decoder, drives address, lane mask, store data, enables and the stall request
`default_nettype none
`timescale 1ns/1ps

module mem_req_gen (
  input  wire                       arst_n_i,
  input  wire mem_op_pkg::aluop_t   aluop_i,
  input  wire cpu_cfg_pkg::word_t   mem_addr_i,
  input  wire cpu_cfg_pkg::word_t   reg2_i,
  input  wire                       sc_pass_i,
  input  wire                       mem_data_valid_i,
  input  wire                       mem_write_ready_i,
  output cpu_cfg_pkg::word_t        mem_addr_o,
  output cpu_cfg_pkg::word_t        mem_data_o,
  output cpu_cfg_pkg::byte_sel_t    mem_sel_o,
  output logic                      mem_ce_o,
  output logic                      mem_we_o,
  output logic                      stall_o
);
  import cpu_cfg_pkg::*;
  import mem_op_pkg::*;

  logic [1:0] offset;
  logic [1:0] inv_offset;
  logic [4:0] shamt_l;
  logic [4:0] shamt_r;
  logic       half_ok;
  logic       ce;
  logic       we;
  word_t      word_addr;
  byte_sel_t  lane_sel;
  byte_sel_t  half_sel;

  assign offset     = mem_addr_i[1:0];
  assign inv_offset = 2'd3 - offset;
  assign shamt_l    = {offset, 3'b000};
  assign shamt_r    = {inv_offset, 3'b000};

  // address with the byte offset dropped, for the unaligned word forms
  assign word_addr = {mem_addr_i[WORD_W-1:2], 2'b00};

  // one lane for bytes, a lane pair for halfwords
  assign lane_sel = 4'b0001 << offset;
  assign half_ok  = ~offset[0];
  assign half_sel = offset[1] ? 4'b1100 : 4'b0011;

  always_comb
  begin
    ce         = 1'b0;
    we         = 1'b0;
    mem_addr_o = ZERO_WORD;
    mem_sel_o  = '1;
    mem_data_o = ZERO_WORD;
    case (aluop_i)
      OP_LB, OP_LBU:
      begin
        ce         = 1'b1;
        mem_addr_o = mem_addr_i;
        mem_sel_o  = lane_sel;
      end
      OP_LH, OP_LHU:
      begin
        ce         = 1'b1;
        mem_addr_o = mem_addr_i;
        // misaligned load still reads the whole word
        mem_sel_o  = half_ok ? half_sel : 4'b1111;
      end
      OP_LW, OP_LL:
      begin
        ce         = 1'b1;
        mem_addr_o = mem_addr_i;
      end
      OP_LWL, OP_LWR:
      begin
        ce         = 1'b1;
        mem_addr_o = word_addr;
      end
      OP_SB:
      begin
        ce         = 1'b1;
        we         = 1'b1;
        mem_addr_o = mem_addr_i;
        mem_sel_o  = lane_sel;
        mem_data_o = {4{reg2_i[7:0]}};
      end
      OP_SH:
      begin
        ce         = 1'b1;
        we         = 1'b1;
        mem_addr_o = mem_addr_i;
        // misaligned store writes no lane at all
        mem_sel_o  = half_ok ? half_sel : 4'b0000;
        mem_data_o = {2{reg2_i[15:0]}};
      end
      OP_SW:
      begin
        ce         = 1'b1;
        we         = 1'b1;
        mem_addr_o = mem_addr_i;
        mem_data_o = reg2_i;
      end
      OP_SWL:
      begin
        ce         = 1'b1;
        we         = 1'b1;
        mem_addr_o = word_addr;
        // upper bytes of reg2 land in the low lanes
        mem_sel_o  = 4'b1111 >> offset;
        mem_data_o = reg2_i >> shamt_l;
      end
      OP_SWR:
      begin
        ce         = 1'b1;
        we         = 1'b1;
        mem_addr_o = word_addr;
        // lower bytes of reg2 land in the high lanes
        mem_sel_o  = 4'b1111 << inv_offset;
        mem_data_o = reg2_i << shamt_r;
      end
      OP_SC:
      begin
        if (sc_pass_i)
        begin
          ce         = 1'b1;
          we         = 1'b1;
          mem_addr_o = mem_addr_i;
          mem_data_o = reg2_i;
        end
      end
      default:
      begin
        ce = 1'b0;
      end
    endcase
  end

  assign mem_ce_o = arst_n_i & ce;
  assign mem_we_o = arst_n_i & we;

  // hold the pipeline until the memory answers
  assign stall_o = (mem_we_o & ~mem_write_ready_i) |
                   (mem_ce_o & ~mem_we_o & ~mem_data_valid_i);

endmodule

`default_nettype wire

//--- rtl/mem_stage.sv
// memory-access stage top, connects the link-bit, request and load-align blocks to the pipeline
`default_nettype none
`timescale 1ns/1ps

module mem_stage (
  input  wire                         clk,
  input  wire                         arst_n_i,
  // from execute
  input  wire mem_op_pkg::aluop_t     aluop_i,
  input  wire cpu_cfg_pkg::word_t     mem_addr_i,
  input  wire cpu_cfg_pkg::word_t     reg2_i,
  input  wire cpu_cfg_pkg::word_t     wdata_i,
  input  wire cpu_cfg_pkg::reg_addr_t wd_i,
  input  wire                         wreg_i,
  // from data memory
  input  wire cpu_cfg_pkg::word_t     mem_data_i,
  input  wire                         mem_data_valid_i,
  input  wire                         mem_write_ready_i,
  // to write-back
  output wire cpu_cfg_pkg::reg_addr_t wd_o,
  output wire                         wreg_o,
  output wire cpu_cfg_pkg::word_t     wdata_o,
  // to data memory
  output wire cpu_cfg_pkg::word_t     mem_addr_o,
  output wire cpu_cfg_pkg::word_t     mem_data_o,
  output wire cpu_cfg_pkg::byte_sel_t mem_sel_o,
  output wire                         mem_ce_o,
  output wire                         mem_we_o,
  // to pipeline control
  output wire                         stall_o
);

  wire sc_pass;
  wire stall;

  assign stall_o = stall;

  llbit_ctrl u_llbit_ctrl (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .aluop_i   (aluop_i),
    .stall_i   (stall),
    .sc_pass_o (sc_pass)
  );

  mem_req_gen u_mem_req_gen (
    .arst_n_i          (arst_n_i),
    .aluop_i           (aluop_i),
    .mem_addr_i        (mem_addr_i),
    .reg2_i            (reg2_i),
    .sc_pass_i         (sc_pass),
    .mem_data_valid_i  (mem_data_valid_i),
    .mem_write_ready_i (mem_write_ready_i),
    .mem_addr_o        (mem_addr_o),
    .mem_data_o        (mem_data_o),
    .mem_sel_o         (mem_sel_o),
    .mem_ce_o          (mem_ce_o),
    .mem_we_o          (mem_we_o),
    .stall_o           (stall)
  );

  load_align u_load_align (
    .arst_n_i   (arst_n_i),
    .aluop_i    (aluop_i),
    .mem_addr_i (mem_addr_i),
    .reg2_i     (reg2_i),
    .mem_data_i (mem_data_i),
    .sc_pass_i  (sc_pass),
    .wd_i       (wd_i),
    .wreg_i     (wreg_i),
    .wdata_i    (wdata_i),
    .wd_o       (wd_o),
    .wreg_o     (wreg_o),
    .wdata_o    (wdata_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
// testbench clock and reset source, 8 ns clock with reset held low for the first 10 cycles
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial
  begin
    arst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/tb_mem_stage.sv
// top-level testbench of the memory-access stage that checks random loads and stores against a model
`default_nettype none
`timescale 1ns/1ps

module tb_mem_stage;
  import cpu_cfg_pkg::*;
  import mem_op_pkg::*;

  logic      clk;
  logic      arst_n;
  aluop_t    aluop;
  word_t     mem_addr;
  word_t     reg2;
  word_t     wdata_in;
  reg_addr_t wd_in;
  logic      wreg_in;
  word_t     rdata;
  logic      data_valid;
  logic      write_ready;
  reg_addr_t wd_o;
  logic      wreg_o;
  word_t     wdata_o;
  word_t     mem_addr_o;
  word_t     mem_data_o;
  byte_sel_t mem_sel_o;
  logic      mem_ce_o;
  logic      mem_we_o;
  logic      stall_o;

  // model state and the values it expects
  logic      llbit_m;
  logic      resp;
  logic      timed_out;
  logic      exp_ce;
  logic      exp_we;
  word_t     exp_addr;
  byte_sel_t exp_sel;
  word_t     exp_data;
  word_t     exp_wdata;
  int        error_count;
  int        check_count;
  aluop_t    op_list [14];

  tb_clk_gen u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  mem_stage dut_i (
    .clk               (clk),
    .arst_n_i          (arst_n),
    .aluop_i           (aluop),
    .mem_addr_i        (mem_addr),
    .reg2_i            (reg2),
    .wdata_i           (wdata_in),
    .wd_i              (wd_in),
    .wreg_i            (wreg_in),
    .mem_data_i        (rdata),
    .mem_data_valid_i  (data_valid),
    .mem_write_ready_i (write_ready),
    .wd_o              (wd_o),
    .wreg_o            (wreg_o),
    .wdata_o           (wdata_o),
    .mem_addr_o        (mem_addr_o),
    .mem_data_o        (mem_data_o),
    .mem_sel_o         (mem_sel_o),
    .mem_ce_o          (mem_ce_o),
    .mem_we_o          (mem_we_o),
    .stall_o           (stall_o)
  );

  task automatic check_val(input string name, input word_t act, input word_t exp);
    begin
      check_count++;
      if (act !== exp)
      begin
        error_count++;
        $display("error at %0t: %s = %h, expected %h", $time, name, act, exp);
      end
    end
  endtask

  task automatic finish_run();
    begin
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
        $display("Simulation completed successfully");
      else
        $display("Simulation failed");
      $finish;
    end
  endtask

  // byte k of a word sits at bits 8k and up and lane k covers it
  task automatic predict();
    int k;
    int i;
    begin
      k         = mem_addr[1:0];
      exp_ce    = 1'b1;
      exp_we    = 1'b0;
      exp_addr  = mem_addr;
      exp_sel   = 4'hf;
      exp_data  = '0;
      exp_wdata = wdata_in;
      case (aluop)
        OP_LB, OP_LBU:
        begin
          exp_sel   = 4'b0001 << k;
          exp_wdata = {24'h0, rdata[8*k +: 8]};
          if (aluop == OP_LB && rdata[8*k+7])
            exp_wdata[31:8] = '1;
        end
        OP_LH, OP_LHU:
        begin
          if (k % 2 == 1)
            exp_wdata = '0;
          else
          begin
            exp_sel   = 4'b0011 << k;
            exp_wdata = {16'h0, rdata[8*k +: 16]};
            if (aluop == OP_LH && rdata[8*k+15])
              exp_wdata[31:16] = '1;
          end
        end
        OP_LW, OP_LL:
          exp_wdata = rdata;
        OP_LWL, OP_LWR:
        begin
          exp_addr[1:0] = 2'b00;
          for (i = 0; i < 4; i++)
          begin
            if (aluop == OP_LWL)
              exp_wdata[8*i +: 8] = (i < k) ? reg2[8*i +: 8] : rdata[8*(i-k) +: 8];
            else
              exp_wdata[8*i +: 8] = (i > k) ? reg2[8*i +: 8] : rdata[8*(i+3-k) +: 8];
          end
        end
        OP_SB:
        begin
          exp_we   = 1'b1;
          exp_sel  = 4'b0001 << k;
          exp_data = {4{reg2[7:0]}};
        end
        OP_SH:
        begin
          exp_we   = 1'b1;
          exp_sel  = (k % 2 == 1) ? 4'b0000 : 4'b0011 << k;
          exp_data = {2{reg2[15:0]}};
        end
        OP_SW:
        begin
          exp_we   = 1'b1;
          exp_data = reg2;
        end
        OP_SWL, OP_SWR:
        begin
          exp_we        = 1'b1;
          exp_addr[1:0] = 2'b00;
          for (i = 0; i < 4; i++)
            exp_sel[i] = (aluop == OP_SWL) ? (i < 4 - k) : (i >= 3 - k);
          exp_data = (aluop == OP_SWL) ? reg2 >> (8 * k) : reg2 << (8 * (3 - k));
        end
        OP_SC:
        begin
          exp_wdata = {31'h0, llbit_m};
          exp_ce    = llbit_m;
          exp_we    = llbit_m;
          exp_data  = llbit_m ? reg2 : '0;
          exp_addr  = llbit_m ? mem_addr : '0;
        end
        default:
        begin
          exp_ce   = 1'b0;
          exp_addr = '0;
        end
      endcase
    end
  endtask

  task automatic compare_outputs();
    begin
      check_val("mem_ce_o", mem_ce_o, exp_ce);
      check_val("mem_we_o", mem_we_o, exp_we);
      check_val("mem_addr_o", mem_addr_o, exp_addr);
      check_val("mem_sel_o", mem_sel_o, exp_sel);
      if (exp_we)
        check_val("mem_data_o", mem_data_o, exp_data);
      check_val("wdata_o", wdata_o, exp_wdata);
      check_val("wd_o", wd_o, wd_in);
      check_val("wreg_o", wreg_o, wreg_in);
      // request held and stall up until the responder answers
      check_val("stall_o", stall_o, exp_ce & ~resp);
    end
  endtask

  // one instruction with the memory answering after 0 to 3 cycles
  task automatic do_access(input aluop_t op, input word_t addr);
    logic [31:0] rnd;
    int          delay;
    int          i;
    int          cnt;
    begin
      if (!timed_out)
      begin
        @(negedge clk);
        rnd      = $urandom;
        aluop    = op;
        mem_addr = addr;
        reg2     = $urandom;
        rdata    = $urandom;
        wdata_in = $urandom;
        wd_in    = rnd[4:0];
        wreg_in  = rnd[5];
        delay    = rnd[9:8];
        predict();
        for (i = 0; i <= delay; i++)
        begin
          if (i > 0)
            @(negedge clk);
          resp = (i == delay);
          // the handshake line of the other direction runs opposite
          data_valid  = exp_we ? ~resp : resp;
          write_ready = exp_we ? resp : ~resp;
          #1;
          compare_outputs();
        end
        cnt = 0;
        while (stall_o !== 1'b0 && cnt < 16)
        begin
          @(negedge clk);
          cnt++;
        end
        if (stall_o !== 1'b0)
        begin
          $display("timeout: stall_o stayed high after the memory answered");
          error_count++;
          timed_out = 1'b1;
        end
        else
        begin
          // completing edge
          @(posedge clk);
          if (op == OP_LL)
            llbit_m = 1'b1;
          else if (op == OP_SC)
            llbit_m = 1'b0;
        end
      end
    end
  endtask

  task automatic run_tests();
    int    n;
    int    k;
    word_t a;
    begin
      // no reservation after reset, then LL, a passing SC and a failing SC
      do_access(OP_SC, $urandom);
      do_access(OP_LL, $urandom);
      do_access(OP_SC, $urandom);
      do_access(OP_SC, $urandom);
      // LL still waiting for data must not arm the next SC
      @(negedge clk);
      aluop       = OP_LL;
      resp        = 1'b0;
      data_valid  = 1'b0;
      write_ready = 1'b0;
      for (n = 0; n < 3; n++)
      begin
        @(negedge clk);
        check_val("stall_o", stall_o, 1'b1);
      end
      do_access(OP_SC, $urandom);
      // every operation at every byte offset
      for (n = 0; n < 14; n++)
      begin
        for (k = 0; k < 4; k++)
        begin
          a      = $urandom;
          a[1:0] = k[1:0];
          do_access(op_list[n], a);
        end
      end
      // random mix including codes with the top bit clear that match no memory operation
      for (n = 0; n < 300; n++)
      begin
        a = $urandom;
        k = $urandom % 16;
        do_access((k < 14) ? op_list[k] : aluop_t'({1'b0, a[14:8]}), a);
      end
    end
  endtask

  initial
  begin
    int cnt;
    void'($urandom(51));
    op_list = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
                OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_LL, OP_SC};
    error_count = 0;
    check_count = 0;
    llbit_m     = 1'b0;
    resp        = 1'b0;
    timed_out   = 1'b0;
    // unanswered store with write-back enabled while in reset
    aluop       = OP_SW;
    mem_addr    = 32'h0000_0100;
    reg2        = '0;
    wdata_in    = '0;
    wd_in       = '0;
    wreg_in     = 1'b1;
    rdata       = '0;
    data_valid  = 1'b0;
    write_ready = 1'b0;
    cnt         = 0;
    while (arst_n !== 1'b1 && cnt < 40)
    begin
      @(negedge clk);
      #1;
      if (arst_n === 1'b0)
      begin
        check_val("mem_ce_o", mem_ce_o, 1'b0);
        check_val("mem_we_o", mem_we_o, 1'b0);
        check_val("wreg_o", wreg_o, 1'b0);
        check_val("stall_o", stall_o, 1'b0);
      end
      cnt++;
    end
    if (arst_n !== 1'b1)
    begin
      $display("timeout: reset was never released");
      error_count++;
    end
    else
      run_tests();
    finish_run();
  end

endmodule

`default_nettype wire
